//--- uart_periph.f
design/uart_bus_pkg.sv
design/uart_frame_pkg.sv
design/uart_regs.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_periph.sv
dv/uart_periph_chk.sv
dv/uart_periph_tb.sv

//--- dv/uart_periph_tb.sv
`timescale 1ns/10ps

module uart_periph_tb
  import uart_bus_pkg::*;
  import uart_frame_pkg::*;
();

localparam int NUM_ENTRIES = 8;
localparam bus_addr_t ADDR_TXDATA  = {REG_TXDATA, 2'b00};
localparam bus_addr_t ADDR_DIVISOR = {REG_DIVISOR, 2'b00};
localparam bus_addr_t ADDR_RXDATA  = {REG_RXDATA, 2'b00};
localparam bus_addr_t ADDR_STATUS  = {REG_STATUS, 2'b00};
localparam bus_addr_t ADDR_UNUSED  = 32'h0000_0040;

typedef enum logic [2:0] {OP_LOOP, OP_BAD_PARITY, OP_BAD_STOP, OP_OVERRUN, OP_FLOW} op_t;

typedef struct packed {
  op_t         op;
  logic        rnd;         // Byte comes from the random generator.
  uart_byte_t  data;
  logic [15:0] div;
  logic [15:0] cts_delay;
  logic [7:0]  exp_status;
} entry_t;

logic        clk = 1'b0;
logic        rst;
logic        bus_req;
logic        bus_write;
bus_addr_t   bus_addr;
bus_data_t   bus_wdata;
bus_mask_t   bus_wr_mask;
logic        bus_ack;
bus_data_t   bus_rdata;
logic        txd;
logic        rxd;
logic        cts;
logic        rts;
logic        loopback;
logic        bb_rxd;
entry_t      stim [NUM_ENTRIES];
logic [15:0] cur_div;
logic [31:0] rng_state = 32'hf155e618;
int          errors = 0;
int          ack_limit;
int          wd_cycles = 0;

assign rxd = loopback ? txd : bb_rxd;

always #20 clk = ~clk;

uart_periph #(
  .DIV_WIDTH (16),
  .DIV_RESET (326)
) DUT (
  .clk           (clk),
  .rst           (rst),
  .i_bus_req     (bus_req),
  .i_bus_write   (bus_write),
  .i_bus_addr    (bus_addr),
  .i_bus_data    (bus_wdata),
  .i_bus_wr_mask (bus_wr_mask),
  .o_bus_ack     (bus_ack),
  .o_bus_data    (bus_rdata),
  .o_txd         (txd),
  .i_rxd         (rxd),
  .i_cts         (cts),
  .o_rts         (rts)
);

bind uart_periph uart_periph_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .i_req      (i_bus_req),
  .i_ack      (o_bus_ack),
  .i_rdata    (o_bus_data),
  .i_txd      (o_txd),
  .i_tx_state (u_tx.state)
);

// **************************************************
// Helpers
// **************************************************

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function uart_byte_t random_byte();
  rng_state = xorshift32(rng_state);
  return rng_state[7:0];
endfunction

function automatic entry_t make_entry(input op_t op, input logic rnd, input uart_byte_t data,
                                      input int div, input int hold, input logic [7:0] exp);
  entry_t e;
  e.op         = op;
  e.rnd        = rnd;
  e.data       = data;
  e.div        = 16'(div);
  e.cts_delay  = 16'(hold);
  e.exp_status = exp;
  return e;
endfunction

// Lanes 0 and 1 hold the divisor. Each lane is written only when its mask bit is set.
function automatic logic [15:0] merge_lanes(input logic [15:0] old, input bus_data_t d,
                                            input bus_mask_t m);
  logic [15:0] r;
  r = old;
  if (m[0])
    r[7:0] = d[7:0];
  if (m[1])
    r[15:8] = d[15:8];
  return r;
endfunction

task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
  assert (got === exp)
  else
    begin
    $display("[ERROR] %s expected %h got %h", name, exp, got);
    errors++;
    end
endtask

task automatic bus_xfer(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                        input bus_mask_t mask, output bus_data_t rdata);
  int waited;
  waited = 0;
  @(posedge clk);
  bus_req     <= 1'b1;
  bus_write   <= wr;
  bus_addr    <= addr;
  bus_wdata   <= wdata;
  bus_wr_mask <= mask;
  @(negedge clk);
  while (!bus_ack && waited < ack_limit)
    begin
    waited++;
    @(negedge clk);
    end
  assert (bus_ack)
  else
    begin
    $display("No bus ack after %0d cycles for address %h", waited, addr);
    errors++;
    end
  rdata = bus_rdata;
  @(posedge clk);
  bus_req <= 1'b0;  // Dropped in the cycle after ack.
endtask

task automatic bus_write_reg(input bus_addr_t addr, input bus_data_t d, input bus_mask_t m);
  bus_data_t unused;
  bus_xfer(1'b1, addr, d, m, unused);
endtask

task automatic bus_read_reg(input bus_addr_t addr, output bus_data_t d);
  bus_xfer(1'b0, addr, '0, 4'h0, d);
endtask

task automatic expect_reg(input string name, input bus_addr_t addr, input bus_data_t exp);
  bus_data_t rd;
  bus_read_reg(addr, rd);
  check_eq(name, exp, rd);
endtask

task automatic expect_rts(input logic exp);
  @(negedge clk);
  check_eq("o_rts", exp, rts);
endtask

task automatic write_divisor(input bus_data_t d, input bus_mask_t m);
  logic [15:0] expected;
  expected = merge_lanes(cur_div, d, m);
  bus_write_reg(ADDR_DIVISOR, d, m);
  repeat (int'(cur_div) + 4) @(posedge clk);  // Old count runs out before the new value loads.
  cur_div = expected;
  expect_reg("DIVISOR", ADDR_DIVISOR, {16'h0, expected});
endtask

task automatic wait_rts_high();
  int waited;
  waited = 0;
  @(negedge clk);
  while (!rts && waited < ack_limit)
    begin
    waited++;
    @(negedge clk);
    end
  assert (rts)
  else
    begin
    $display("No received byte reported within %0d cycles", waited);
    errors++;
    end
endtask

task automatic wait_tx_idle();
  bus_data_t st;
  int polls;
  polls = 0;
  bus_read_reg(ADDR_STATUS, st);
  while (st[STAT_TX_BUSY] && polls < ack_limit)
    begin
    polls++;
    bus_read_reg(ADDR_STATUS, st);
    end
  assert (!st[STAT_TX_BUSY])
  else
    begin
    $display("Transmitter still busy after %0d status polls", polls);
    errors++;
    end
endtask

task automatic send_frame(input uart_byte_t b, input logic bad_parity, input logic bad_stop);
  logic [FRAME_BITS-1:0] bits;
  bits = {~bad_stop, 1'b1, (^b) ^ bad_parity, b, 1'b0};
  for (int i = 0; i < FRAME_BITS; i++)
    begin
    @(posedge clk);
    bb_rxd <= bits[i];
    repeat (OVERSAMPLE * int'(cur_div) - 1) @(posedge clk);
    end
  @(posedge clk);
  bb_rxd <= 1'b1;
endtask

// Samples TXD at mid-bit, timed from the falling edge of the start bit.
task automatic capture_frame(output uart_byte_t b);
  logic [FRAME_BITS-1:0] bits;
  int waited;
  int bit_clks;
  waited   = 0;
  bit_clks = OVERSAMPLE * int'(cur_div);
  @(negedge clk);
  while (txd && waited < ack_limit)
    begin
    waited++;
    @(negedge clk);
    end
  assert (!txd)
  else
    begin
    $display("No start bit on TXD within %0d cycles", waited);
    errors++;
    end
  repeat (bit_clks / 2) @(negedge clk);
  for (int i = 0; i < FRAME_BITS; i++)
    begin
    bits[i] = txd;
    if (i < FRAME_BITS - 1)
      repeat (bit_clks) @(negedge clk);
    end
  check_eq("o_txd start bit", 32'h0, bits[0]);
  check_eq("o_txd parity bit", ^bits[8:1], bits[9]);
  check_eq("o_txd stop bits", 32'h3, bits[11:10]);
  b = bits[8:1];
endtask

// **************************************************
// Table operations
// **************************************************

task automatic run_loopback(input uart_byte_t b, input bus_data_t exp);
  @(posedge clk);
  loopback <= 1'b1;
  bus_write_reg(ADDR_TXDATA, b, 4'hf);
  wait_rts_high();
  wait_tx_idle();
  expect_reg("STATUS", ADDR_STATUS, exp);
  expect_reg("RXDATA", ADDR_RXDATA, b);
  expect_reg("STATUS", ADDR_STATUS, 32'h0);
  expect_rts(1'b0);
endtask

task automatic run_bad_frame(input uart_byte_t b, input logic bad_parity, input logic bad_stop,
                             input bus_data_t exp);
  @(posedge clk);
  loopback <= 1'b0;
  send_frame(b, bad_parity, bad_stop);
  wait_rts_high();
  expect_reg("STATUS", ADDR_STATUS, exp);
  expect_reg("RXDATA", ADDR_RXDATA, b);
  expect_reg("STATUS", ADDR_STATUS, 32'h0);
endtask

task automatic run_overrun(input uart_byte_t a, input uart_byte_t b, input bus_data_t exp);
  @(posedge clk);
  loopback <= 1'b0;
  send_frame(a, 1'b0, 1'b0);
  wait_rts_high();
  expect_rts(1'b1);
  send_frame(b, 1'b0, 1'b0);
  expect_reg("STATUS", ADDR_STATUS, exp);
  expect_reg("RXDATA", ADDR_RXDATA, b);  // The second byte overwrote the first.
  expect_reg("STATUS", ADDR_STATUS, 32'h0);
  expect_rts(1'b0);
endtask

task automatic run_flow(input uart_byte_t a, input uart_byte_t b, input int hold,
                        input bus_data_t exp);
  uart_byte_t got;
  logic       second_acked;
  logic       first_done;
  int         low_cycles;
  second_acked = 1'b0;
  first_done   = 1'b0;
  low_cycles   = 0;
  @(posedge clk);
  loopback <= 1'b0;
  cts      <= 1'b1;
  bus_write_reg(ADDR_TXDATA, a, 4'hf);
  expect_reg("STATUS", ADDR_STATUS, exp);
  fork
    begin
    bus_write_reg(ADDR_TXDATA, b, 4'hf);
    second_acked = 1'b1;
    assert (first_done)
    else
      begin
      $display("Second TXDATA write acknowledged before the first frame completed");
      errors++;
      end
    end
    begin
    repeat (hold)
      begin
      @(negedge clk);
      if (!txd)
        low_cycles++;
      end
    check_eq("o_txd low cycles while CTS high", 32'h0, low_cycles);
    assert (!second_acked)
    else
      begin
      $display("Second TXDATA write acknowledged while CTS was high");
      errors++;
      end
    @(posedge clk);
    cts <= 1'b0;
    capture_frame(got);
    first_done = 1'b1;
    check_eq("o_txd first frame byte", a, got);
    capture_frame(got);
    check_eq("o_txd second frame byte", b, got);
    end
  join
  wait_tx_idle();
endtask

// **************************************************
// Main sequence
// **************************************************

initial
  begin
  entry_t     e;
  uart_byte_t b;
  int         max_div;
  int         max_hold;
  int         frame_clks;
  int         total;
  rst         = 1'b1;
  bus_req     = 1'b0;
  bus_write   = 1'b0;
  bus_addr    = '0;
  bus_wdata   = '0;
  bus_wr_mask = '0;
  cts         = 1'b0;
  loopback    = 1'b0;
  bb_rxd      = 1'b1;
  cur_div     = 16'd326;

  stim[0] = make_entry(OP_LOOP,       1'b0, 8'h55, 4, 0,   8'h02);
  stim[1] = make_entry(OP_LOOP,       1'b1, 8'h00, 6, 0,   8'h02);
  stim[2] = make_entry(OP_LOOP,       1'b0, 8'ha3, 8, 0,   8'h02);
  stim[3] = make_entry(OP_BAD_PARITY, 1'b0, 8'h3c, 5, 0,   8'h06);
  stim[4] = make_entry(OP_BAD_STOP,   1'b0, 8'hc1, 5, 0,   8'h0a);
  stim[5] = make_entry(OP_OVERRUN,    1'b0, 8'h7e, 4, 0,   8'h12);
  stim[6] = make_entry(OP_FLOW,       1'b0, 8'h96, 6, 700, 8'h01);
  stim[7] = make_entry(OP_LOOP,       1'b1, 8'h00, 3, 0,   8'h02);

  max_div  = 0;
  max_hold = 0;
  for (int i = 0; i < NUM_ENTRIES; i++)
    begin
    if (int'(stim[i].div) > max_div)
      max_div = int'(stim[i].div);
    if (int'(stim[i].cts_delay) > max_hold)
      max_hold = int'(stim[i].cts_delay);
    end
  frame_clks = FRAME_BITS * OVERSAMPLE * max_div;
  ack_limit  = 2 * frame_clks + max_hold + 100;
  wd_cycles  = NUM_ENTRIES * 14 * frame_clks + 20000;

  repeat (8) @(posedge clk);
  rst <= 1'b0;
  @(negedge clk);
  check_eq("o_txd", 32'h1, txd);
  check_eq("o_rts", 32'h0, rts);
  check_eq("o_bus_ack", 32'h0, bus_ack);

  expect_reg("DIVISOR", ADDR_DIVISOR, 32'd326);
  expect_reg("STATUS", ADDR_STATUS, 32'h0);
  write_divisor(32'hdead_beab, 4'b0001);
  write_divisor(32'h0000_0500, 4'b0010);
  write_divisor(32'hffff_ffff, 4'b1100);  // Upper lanes hold no divisor bits.
  write_divisor(32'h1234_0008, 4'b0011);
  expect_reg("unmapped read", ADDR_UNUSED, 32'h0);
  bus_write_reg(ADDR_UNUSED, 32'h5a5a_5a5a, 4'hf);

  for (int i = 0; i < NUM_ENTRIES; i++)
    begin
    e = stim[i];
    if (e.div != cur_div)
      write_divisor({16'h0, e.div}, 4'b0011);
    b = e.rnd ? random_byte() : e.data;
    case (e.op)
      OP_LOOP:       run_loopback(b, e.exp_status);
      OP_BAD_PARITY: run_bad_frame(b, 1'b1, 1'b0, e.exp_status);
      OP_BAD_STOP:   run_bad_frame(b, 1'b0, 1'b1, e.exp_status);
      OP_OVERRUN:    run_overrun(b, random_byte(), e.exp_status);
      OP_FLOW:       run_flow(b, random_byte(), int'(e.cts_delay), e.exp_status);
      default:
        begin
        $display("Unknown operation in table entry %0d", i);
        errors++;
        end
    endcase
    end

  repeat (4) @(posedge clk);
  total = errors + DUT.u_chk.fails;
  $display("Errors: %0d (checks %0d, assertions %0d)", total, errors, DUT.u_chk.fails);
  if (total == 0)
    $display("Test OK");
  else
    $display("Test FAILED");
  $finish;
  end

initial
  begin
  wait (wd_cycles > 0);
  repeat (wd_cycles) @(posedge clk);
  $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
  $display("Errors: %0d (checks %0d, assertions %0d)", errors + DUT.u_chk.fails + 1,
           errors, DUT.u_chk.fails);
  $display("Test FAILED");
  $finish;
  end

endmodule

//--- dv/uart_periph_chk.sv
`timescale 1ns/10ps

module uart_periph_chk
  import uart_frame_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        i_req,
  input logic        i_ack,
  input logic [31:0] i_rdata,
  input logic        i_txd,
  input tx_state_t   i_tx_state
);

int unsigned fails = 0;  // Failed assertions so far.

// **************************************************
// Bus handshake
// **************************************************

ack_single: assert property (@(posedge clk) disable iff (rst) i_ack |=> !i_ack)
  else
    begin
    fails++;
    $error("Bus ack stayed high for two cycles");
    end

ack_after_req: assert property (@(posedge clk) disable iff (rst) i_ack |-> $past(i_req))
  else
    begin
    fails++;
    $error("Bus ack without a request in the cycle before");
    end

rdata_zero: assert property (@(posedge clk) disable iff (rst) !i_ack |-> (i_rdata == '0))
  else
    begin
    fails++;
    $error("Bus read data not zero outside the ack cycle");
    end

// **************************************************
// Line side
// **************************************************

txd_idle_high: assert property (@(posedge clk) disable iff (rst)
                                (i_tx_state == TX_IDLE) |-> i_txd)
  else
    begin
    fails++;
    $error("TXD low while the transmitter is idle");
    end

endmodule

//--- design/uart_periph.sv
`timescale 1ns/10ps

module uart_periph
  import uart_bus_pkg::*;
  import uart_frame_pkg::*;
#(
  parameter int DIV_WIDTH = 16,
  parameter int DIV_RESET = 326
)
(
  input  logic      clk,
  input  logic      rst,

  input  logic      i_bus_req,
  input  logic      i_bus_write,
  input  bus_addr_t i_bus_addr,
  input  bus_data_t i_bus_data,
  input  bus_mask_t i_bus_wr_mask,
  output logic      o_bus_ack,
  output bus_data_t o_bus_data,

  output logic      o_txd,
  input  logic      i_rxd,
  input  logic      i_cts,
  output logic      o_rts
);

logic                 tx_start;
uart_byte_t           tx_byte;
logic                 tx_busy;
logic [DIV_WIDTH-1:0] divisor;
logic                 tick;
logic                 rx_done;
uart_byte_t           rx_byte;
logic                 rx_parity_err;
logic                 rx_frame_err;

uart_regs #(
  .DIV_WIDTH (DIV_WIDTH),
  .DIV_RESET (DIV_RESET)
) u_regs (
  .clk             (clk),
  .rst             (rst),
  .i_bus_req       (i_bus_req),
  .i_bus_write     (i_bus_write),
  .i_bus_addr      (i_bus_addr),
  .i_bus_data      (i_bus_data),
  .i_bus_wr_mask   (i_bus_wr_mask),
  .o_bus_ack       (o_bus_ack),
  .o_bus_data      (o_bus_data),
  .o_tx_start      (tx_start),
  .o_tx_byte       (tx_byte),
  .i_tx_busy       (tx_busy),
  .o_divisor       (divisor),
  .i_rx_done       (rx_done),
  .i_rx_byte       (rx_byte),
  .i_rx_parity_err (rx_parity_err),
  .i_rx_frame_err  (rx_frame_err),
  .o_rts           (o_rts)
);

uart_baud_gen #(
  .DIV_WIDTH (DIV_WIDTH)
) u_baud (
  .clk       (clk),
  .rst       (rst),
  .i_divisor (divisor),
  .o_tick    (tick)
);

uart_tx u_tx (
  .clk     (clk),
  .rst     (rst),
  .i_tick  (tick),
  .i_start (tx_start),
  .i_byte  (tx_byte),
  .i_cts   (i_cts),
  .o_busy  (tx_busy),
  .o_txd   (o_txd)
);

uart_rx u_rx (
  .clk          (clk),
  .rst          (rst),
  .i_tick       (tick),
  .i_rxd        (i_rxd),
  .o_done       (rx_done),
  .o_byte       (rx_byte),
  .o_parity_err (rx_parity_err),
  .o_frame_err  (rx_frame_err)
);

endmodule

//--- design/uart_rx.sv
`timescale 1ns/10ps

module uart_rx
  import uart_frame_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_tick,
  input  logic       i_rxd,
  output logic       o_done,
  output uart_byte_t o_byte,
  output logic       o_parity_err,
  output logic       o_frame_err
);

rx_state_t  state;
logic       rxd_meta;
logic       rxd_sync;
logic       rxd_prev;
logic       fall;
logic       mid_start;
logic       mid_bit;
os_cnt_t    os_cnt;
bit_cnt_t   bit_cnt;
uart_byte_t data;
logic       par_bit;
logic       stop1;

// **************************************************
// Input synchronizer and edge detect
// **************************************************

always_ff @(posedge clk)
  begin
  if (rst)
    begin
    rxd_meta <= 1'b1;
    rxd_sync <= 1'b1;
    rxd_prev <= 1'b1;
    end
  else
    begin
    rxd_meta <= i_rxd;
    rxd_sync <= rxd_meta;
    rxd_prev <= rxd_sync;
    end
  end

assign fall      = rxd_prev && !rxd_sync;
assign mid_start = i_tick && (os_cnt == os_cnt_t'(OVERSAMPLE / 2 - 1));  // 8th tick.
assign mid_bit   = i_tick && (os_cnt == os_cnt_t'(OVERSAMPLE - 1));      // One bit later.

// **************************************************
// Receive FSM
// **************************************************

always_ff @(posedge clk)
  begin
  if (rst)
    begin
    state   <= RX_IDLE;
    o_done  <= 1'b0;
    os_cnt  <= '0;
    bit_cnt <= '0;
    end
  else
    begin
    o_done <= 1'b0;
    if (i_tick)
      os_cnt <= os_cnt + 1'b1;
    case (state)
      RX_IDLE:
        begin
        os_cnt <= '0;
        if (fall)
          state <= RX_START;
        end
      RX_START:
        begin
        if (mid_start)
          begin
          os_cnt  <= '0;
          bit_cnt <= '0;
          state   <= rxd_sync ? RX_IDLE : RX_DATA;  // High at mid-bit is a glitch.
          end
        end
      RX_DATA:
        begin
        if (mid_bit)
          begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd7)
            state <= RX_PARITY;
          end
        end
      RX_PARITY:
        begin
        if (mid_bit)
          begin
          bit_cnt <= '0;
          state   <= RX_STOP;
          end
        end
      RX_STOP:
        begin
        if (mid_bit)
          begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt != '0)
            begin
            o_done <= 1'b1;  // Middle of the second stop bit.
            state  <= RX_IDLE;
            end
          end
        end
      default:
        state <= RX_IDLE;
    endcase
    end
  end

// **************************************************
// Sampled payload and checks
// **************************************************

always_ff @(posedge clk)
  begin
  if (state == RX_DATA && mid_bit)
    data <= {rxd_sync, data[7:1]};
  if (state == RX_PARITY && mid_bit)
    par_bit <= rxd_sync;
  if (state == RX_STOP && mid_bit && bit_cnt == '0)
    stop1 <= rxd_sync;
  if (state == RX_STOP && mid_bit && bit_cnt != '0)
    begin
    o_byte       <= data;
    o_parity_err <= par_bit ^ (^data);  // Even parity.
    o_frame_err  <= !stop1 || !rxd_sync;
    end
  end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx
  import uart_frame_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_tick,
  input  logic       i_start,
  input  uart_byte_t i_byte,
  input  logic       i_cts,
  output logic       o_busy,
  output logic       o_txd
);

tx_state_t state;
frame_t    shreg;
os_cnt_t   os_cnt;
bit_cnt_t  bit_cnt;
logic      load;
logic      go;
logic      bit_end;
logic      last_bit;
logic      shift;

assign load     = (state == TX_IDLE) && i_start;
assign go       = (state == TX_WAIT_CTS) && i_tick && !i_cts;
assign bit_end  = (state == TX_SHIFT) && i_tick && (os_cnt == os_cnt_t'(OVERSAMPLE - 1));
assign last_bit = (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));
assign shift    = go || (bit_end && !last_bit);
assign o_busy   = (state != TX_IDLE);

// Two stop bits, even parity, data LSB first, start bit.
always_ff @(posedge clk)
  begin
  if (load)
    shreg <= {2'b11, ^i_byte, i_byte, 1'b0};
  else if (shift)
    shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
  end

always_ff @(posedge clk)
  begin
  if (rst)
    begin
    state   <= TX_IDLE;
    o_txd   <= 1'b1;
    os_cnt  <= '0;
    bit_cnt <= '0;
    end
  else
    begin
    case (state)
      TX_IDLE:
        begin
        if (i_start)
          state <= TX_WAIT_CTS;
        end
      TX_WAIT_CTS:
        begin
        if (go)
          begin
          state   <= TX_SHIFT;  // CTS is no longer looked at.
          o_txd   <= shreg[0];
          os_cnt  <= '0;
          bit_cnt <= '0;
          end
        end
      TX_SHIFT:
        begin
        if (i_tick)
          os_cnt <= os_cnt + 1'b1;
        if (bit_end && last_bit)
          begin
          state <= TX_IDLE;
          o_txd <= 1'b1;
          end
        else if (bit_end)
          begin
          bit_cnt <= bit_cnt + 1'b1;
          o_txd   <= shreg[0];
          end
        end
      default:
        state <= TX_IDLE;
    endcase
    end
  end

endmodule

//--- design/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen
#(
  parameter int DIV_WIDTH = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [DIV_WIDTH-1:0] i_divisor,
  output logic                 o_tick
);

logic [DIV_WIDTH-1:0] cnt;
logic                 reload;

assign reload = (cnt == '0);

// One tick every i_divisor clocks, 16 ticks per bit.
always_ff @(posedge clk)
  begin
  if (rst)
    begin
    cnt    <= '0;
    o_tick <= 1'b0;
    end
  else
    begin
    o_tick <= reload;
    if (reload)
      cnt <= i_divisor - 1'b1;  // A new divisor is picked up here.
    else
      cnt <= cnt - 1'b1;
    end
  end

endmodule

//--- design/uart_regs.sv
`timescale 1ns/10ps

module uart_regs
  import uart_bus_pkg::*;
  import uart_frame_pkg::*;
#(
  parameter int DIV_WIDTH = 16,
  parameter int DIV_RESET = 326
)
(
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 i_bus_req,
  input  logic                 i_bus_write,
  input  bus_addr_t            i_bus_addr,
  input  bus_data_t            i_bus_data,
  input  bus_mask_t            i_bus_wr_mask,
  output logic                 o_bus_ack,
  output bus_data_t            o_bus_data,

  output logic                 o_tx_start,
  output uart_byte_t           o_tx_byte,
  input  logic                 i_tx_busy,

  output logic [DIV_WIDTH-1:0] o_divisor,

  input  logic                 i_rx_done,
  input  uart_byte_t           i_rx_byte,
  input  logic                 i_rx_parity_err,
  input  logic                 i_rx_frame_err,

  output logic                 o_rts
);

bus_word_t            word;
logic                 req_new;
logic                 tx_write;
logic                 tx_stall;
logic                 respond;
logic                 rx_clear;
bus_data_t            div_wide;
bus_data_t            rd_data;
bus_data_t            status;
logic [DIV_WIDTH-1:0] divisor;
uart_byte_t           rx_byte;
logic                 rx_valid;
logic                 parity_err;
logic                 frame_err;
logic                 overrun;

// **************************************************
// Request decode
// **************************************************

assign word     = i_bus_addr[31:2];
assign req_new  = i_bus_req && !o_bus_ack;  // Req is still high in the ack cycle.
assign tx_write = req_new && i_bus_write && (word == REG_TXDATA);
assign tx_stall = tx_write && i_tx_busy;    // Request stays pending, ack withheld.
assign respond  = req_new && !tx_stall;
assign rx_clear = respond && !i_bus_write && (word == REG_RXDATA);

always_comb
  begin
  div_wide = bus_data_t'(divisor);
  for (int lane = 0; lane < 2; lane++)
    begin
    if (i_bus_wr_mask[lane])
      div_wide[lane*8 +: 8] = i_bus_data[lane*8 +: 8];
    end
  end

always_comb
  begin
  status                  = '0;
  status[STAT_TX_BUSY]    = i_tx_busy || o_tx_start;  // Covers the cycle before busy rises.
  status[STAT_RX_VALID]   = rx_valid;
  status[STAT_PARITY_ERR] = parity_err;
  status[STAT_FRAME_ERR]  = frame_err;
  status[STAT_OVERRUN]    = overrun;
  end

always_comb
  begin
  case (word)
    REG_DIVISOR: rd_data = bus_data_t'(divisor);
    REG_RXDATA:  rd_data = bus_data_t'(rx_byte);
    REG_STATUS:  rd_data = status;
    default:     rd_data = '0;
  endcase
  end

// **************************************************
// Bus response, divisor and transmit start
// **************************************************

always_ff @(posedge clk)
  begin
  if (rst)
    begin
    o_bus_ack  <= 1'b0;
    o_bus_data <= '0;
    o_tx_start <= 1'b0;
    divisor    <= DIV_WIDTH'(DIV_RESET);
    end
  else
    begin
    o_bus_ack  <= respond;
    o_bus_data <= (respond && !i_bus_write) ? rd_data : '0;
    o_tx_start <= tx_write && !i_tx_busy;  // Pulse lines up with the ack.
    if (respond && i_bus_write && (word == REG_DIVISOR))
      divisor <= div_wide[DIV_WIDTH-1:0];
    end
  end

always_ff @(posedge clk)
  begin
  if (tx_write && !i_tx_busy)
    o_tx_byte <= uart_byte_t'(i_bus_data[7:0]);
  end

// **************************************************
// Receive byte and sticky flags
// **************************************************

always_ff @(posedge clk)
  begin
  if (rst)
    begin
    rx_valid   <= 1'b0;
    parity_err <= 1'b0;
    frame_err  <= 1'b0;
    overrun    <= 1'b0;
    end
  else if (i_rx_done)
    begin
    rx_valid   <= 1'b1;
    parity_err <= (parity_err && !rx_clear) || i_rx_parity_err;
    frame_err  <= (frame_err && !rx_clear) || i_rx_frame_err;
    overrun    <= (overrun || rx_valid) && !rx_clear;  // Unread byte gets overwritten.
    end
  else if (rx_clear)
    begin
    rx_valid   <= 1'b0;
    parity_err <= 1'b0;
    frame_err  <= 1'b0;
    overrun    <= 1'b0;
    end
  end

always_ff @(posedge clk)
  begin
  if (i_rx_done)
    rx_byte <= i_rx_byte;
  end

assign o_divisor = divisor;
assign o_rts     = rx_valid;  // Asks the far end to hold off.

endmodule

//--- design/uart_frame_pkg.sv
package uart_frame_pkg;

localparam int unsigned OVERSAMPLE = 16;  // Ticks per bit.
localparam int unsigned FRAME_BITS = 12;  // Start, 8 data, parity, 2 stop.

typedef logic [7:0]            uart_byte_t;
typedef logic [FRAME_BITS-1:0] frame_t;
typedef logic [3:0]            os_cnt_t;   // Tick position inside one bit.
typedef logic [3:0]            bit_cnt_t;  // Bit position inside one frame.

// **************************************************
// State machines
// **************************************************

typedef enum logic [1:0] {
  TX_IDLE,
  TX_WAIT_CTS,
  TX_SHIFT
} tx_state_t;

typedef enum logic [2:0] {
  RX_IDLE,
  RX_START,
  RX_DATA,
  RX_PARITY,
  RX_STOP
} rx_state_t;

endpackage

//--- design/uart_bus_pkg.sv
package uart_bus_pkg;

// **************************************************
// Bus field types
// **************************************************

typedef logic [31:0] bus_addr_t;
typedef logic [31:0] bus_data_t;
typedef logic [3:0]  bus_mask_t;
typedef logic [29:0] bus_word_t;  // Word index, address bits 31 down to 2.

// **************************************************
// Register map
// **************************************************

localparam bus_word_t REG_TXDATA  = 30'd0;
localparam bus_word_t REG_DIVISOR = 30'd1;
localparam bus_word_t REG_RXDATA  = 30'd2;
localparam bus_word_t REG_STATUS  = 30'd3;

// STATUS bit positions.
localparam int unsigned STAT_TX_BUSY    = 0;
localparam int unsigned STAT_RX_VALID   = 1;
localparam int unsigned STAT_PARITY_ERR = 2;
localparam int unsigned STAT_FRAME_ERR  = 3;
localparam int unsigned STAT_OVERRUN    = 4;

endpackage
